/* compile.f */
rtl/vz_pkg.sv
rtl/vz_main_ram.sv
rtl/vz_video_ram.sv
rtl/vz_keyboard.sv
rtl/vz_io_ports.sv
rtl/vz_frame_irq.sv
rtl/vz_bus_decode.sv
rtl/vz_top.sv
tb/tb_vz_top.sv

/* Makefile */
TOP = tb_vz_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module vz_top
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

/* tb/tb_vz_top.sv */
`timescale 1ns/1ns

module tb_vz_top;

	localparam int ACK_TIMEOUT = 20;  // Cycles per bus access
	localparam int IRQ_TIMEOUT = 400; // Longer than one frame
	localparam logic [7:0] FREE_PORTS [4] = '{8'h00, 8'h21, 8'h2C, 8'hFE};

	logic        CLK50MHZ       = 1'b0;
	logic        RESET_N        = 1'b0;
	logic        wb_cyc_i       = 1'b0;
	logic        wb_stb_i       = 1'b0;
	logic        wb_we_i        = 1'b0;
	logic        io_sel_i       = 1'b0;
	logic [15:0] wb_adr_i       = '0;
	logic [7:0]  wb_dat_i       = '0;
	logic [10:0] vid_addr_i     = '0; // Display side of the video RAM
	logic        key_strobe_i   = 1'b0;
	logic [7:0]  key_code_i     = '0;
	logic        key_pressed_i  = 1'b0;
	logic        key_extended_i = 1'b0;
	logic        cass_in_i      = 1'b0;
	logic [4:0]  joy1_i         = '0;
	logic [4:0]  joy2_i         = '0;
	logic        arm1_i         = 1'b0;
	logic        arm2_i         = 1'b0;
	logic [7:0]  wb_dat_o;
	logic        wb_ack_o;
	logic [7:0]  vid_data_o;
	logic [1:0]  spk_o;
	logic        cass_out_o;
	logic        ag_o;
	logic        css_o;
	logic [2:0]  gfx_mode_o;
	logic        irq_o;
	int          errors = 0;
	int          checks = 0;
	logic [31:0] rng_state = 32'h42710fd4;
	logic [7:0]  ref_mem [0:65535]; // Last byte written per address
	logic [15:0] written [$];

	vz_top #(.FRAME_CYCLES(200), .IRQ_CYCLES(20)) u_dut (.*);

	always #10 CLK50MHZ = ~CLK50MHZ; // 50 MHz

	// One wait state, then ack for a single cycle
	ack_after_strobe: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		(wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
	else
	begin
		errors++;
		$display("Error at %0t: no acknowledge one cycle after the strobe", $time);
	end
	ack_one_cycle: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		wb_ack_o |=> !wb_ack_o)
	else
	begin
		errors++;
		$display("Error at %0t: acknowledge held longer than one cycle", $time);
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("Error at %0t: %s gave %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$finish;
	endtask

	// Single Wishbone access, data sampled at the negedge of the ack cycle
	task automatic bus_cycle(input logic io, input logic we, input logic [15:0] adr,
		input logic [7:0] wdat, output logic [7:0] rdat);
		int n;
		@(posedge CLK50MHZ);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		io_sel_i <= io;
		wb_adr_i <= adr;
		wb_dat_i <= wdat;
		n = 0;
		do
		begin
			@(negedge CLK50MHZ);
			n++;
		end
		while (!wb_ack_o && n < ACK_TIMEOUT);
		if (!wb_ack_o)
			abort_run($sformatf("Timeout waiting for wb_ack_o at address %04h", adr));
		else
		begin
			rdat = wb_dat_o;
			@(posedge CLK50MHZ);
			wb_cyc_i <= 1'b0; // Strobe dropped after the ack
			wb_stb_i <= 1'b0;
			wb_we_i  <= 1'b0;
		end
	endtask

	task automatic read_check(input logic io, input logic [15:0] adr, input logic [7:0] exp,
		input string what);
		logic [7:0] got;
		bus_cycle(io, 1'b0, adr, 8'h00, got);
		check_value(got, exp, what);
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed, input logic ext);
		@(posedge CLK50MHZ);
		key_strobe_i   <= 1'b1;
		key_code_i     <= code;
		key_pressed_i  <= pressed;
		key_extended_i <= ext;
		@(posedge CLK50MHZ); // Matrix takes the event here
		key_strobe_i   <= 1'b0;
	endtask

	task automatic check_video(input logic [10:0] adr, input logic [7:0] exp);
		@(posedge CLK50MHZ);
		vid_addr_i <= adr;
		@(posedge CLK50MHZ);
		@(negedge CLK50MHZ); // One cycle after the address
		check_value(vid_data_o, exp, "Video port");
	endtask

	task automatic wait_irq(input logic level, output int cycles);
		cycles = 0;
		do
		begin
			@(negedge CLK50MHZ);
			cycles++;
		end
		while (irq_o !== level && cycles < IRQ_TIMEOUT);
		if (irq_o !== level)
			abort_run("Timeout waiting for irq_o to change level");
	endtask

	initial
	begin
		logic [31:0] r;
		logic [15:0] a;
		logic [7:0]  d;
		int          i;
		int          n_low;
		int          n_high;
		repeat (2) @(posedge CLK50MHZ);
		RESET_N <= 1'b1;
		@(negedge CLK50MHZ);
		check_value({spk_o, cass_out_o, ag_o, css_o, gfx_mode_o}, 8'b0000_0010, "Latch reset");
		check_value({7'd0, irq_o}, 8'd1, "irq_o after reset");

		// Random writes, every fourth one into video RAM
		for (i = 0; i < 32; i++)
		begin
			r = next_rand();
			a = (i % 4 == 3) ? 16'h7000 + {5'd0, r[10:0]} : 16'h7800 + {2'd0, r[13:0]};
			d = r[31:24];
			bus_cycle(1'b0, 1'b1, a, d, d);
			ref_mem[a] = r[31:24];
			written.push_back(a);
			if (a < 16'h7800)
				check_video(a[10:0], ref_mem[a]);
		end
		for (i = 0; i < written.size(); i++)
			read_check(1'b0, written[i], ref_mem[written[i]], "Memory readback");

		// Unmapped memory on both sides, then free I/O ports
		for (i = 0; i < 8; i++)
		begin
			r = next_rand();
			read_check(1'b0, r[15:0] % 16'h6800, 8'hFF, "Memory below 6800");
			read_check(1'b0, 16'hB800 + r[31:16] % 16'h4800, 8'hFF, "Memory above B7FF");
			read_check(1'b1, {r[23:16], FREE_PORTS[i % 4]}, 8'hFF, "Unused I/O port");
		end

		send_key(8'h1C, 1'b1, 1'b0); // A in row A1, column 4
		read_check(1'b0, 16'h68FD, 8'hEF, "Key A down");
		send_key(8'h1C, 1'b0, 1'b0);
		read_check(1'b0, 16'h68FD, 8'hFF, "Key A up");
		send_key(8'h6B, 1'b1, 1'b1); // Left arrow
		read_check(1'b0, 16'h68FD, 8'hFB, "Ctrl from left arrow");
		read_check(1'b0, 16'h68EF, 8'hDF, "M from left arrow");
		send_key(8'h6B, 1'b0, 1'b1);
		read_check(1'b0, 16'h68EF, 8'hFF, "Left arrow up");
		@(posedge CLK50MHZ);
		cass_in_i <= 1'b1;
		read_check(1'b0, 16'h68FF, 8'hBF, "Cassette in high"); // Bit 6 inverted

		for (i = 0; i < 4; i++)
		begin
			r = next_rand();
			bus_cycle(1'b0, 1'b1, 16'h6800, r[7:0], d);
			bus_cycle(1'b1, 1'b1, {r[31:24], 8'h20}, r[15:8], d);
			@(negedge CLK50MHZ);
			check_value({spk_o, cass_out_o, ag_o, css_o, 3'd0},
				{r[0], r[5], r[2], r[3], r[4], 3'd0}, "Output latch");
			check_value({5'd0, gfx_mode_o}, {5'd0, r[12:10]}, "Mode register");
		end

		// Joystick levels, active low on the bus
		for (i = 0; i < 6; i++)
		begin
			r = next_rand();
			@(posedge CLK50MHZ);
			joy1_i <= r[4:0];
			joy2_i <= r[9:5];
			arm1_i <= r[10];
			arm2_i <= r[11];
			read_check(1'b1, {r[31:24], 8'h2E}, {3'b111, ~r[4:0]}, "Joystick 1 direction");
			read_check(1'b1, {r[23:16], 8'h27}, {3'b111, ~r[11], 4'hF}, "Joystick 2 arm");
		end

		wait_irq(1'b1, n_high);
		wait_irq(1'b0, n_high); // Aligned to a falling edge
		for (i = 0; i < 3; i++)
		begin
			wait_irq(1'b1, n_low);
			wait_irq(1'b0, n_high);
			check_value(8'(n_high), 8'd20, "irq_o high cycles");
			check_value(8'(n_low + n_high), 8'd200, "Frame length");
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* rtl/vz_top.sv */
`timescale 1ns/1ns

module vz_top #(
	parameter int FRAME_CYCLES = 1000000,
	parameter int IRQ_CYCLES   = 3200,
	parameter bit GFX_MODE_EN  = 1'b1
) (
	input  logic                           CLK50MHZ,
	input  logic                           RESET_N,
	input  logic                           wb_cyc_i,
	input  logic                           wb_stb_i,
	input  logic                           wb_we_i,
	input  logic                           io_sel_i,
	input  vz_pkg::vz_addr_u               wb_adr_i,
	input  logic [7:0]                     wb_dat_i,
	output logic [7:0]                     wb_dat_o,
	output logic                           wb_ack_o,
	input  logic [vz_pkg::VRAM_ADDR_W-1:0] vid_addr_i,
	output logic [7:0]                     vid_data_o,
	input  logic                           key_strobe_i,
	input  logic [7:0]                     key_code_i,
	input  logic                           key_pressed_i,
	input  logic                           key_extended_i,
	input  logic                           cass_in_i,
	input  logic [4:0]                     joy1_i,
	input  logic [4:0]                     joy2_i,
	input  logic                           arm1_i,
	input  logic                           arm2_i,
	output logic [1:0]                     spk_o,
	output logic                           cass_out_o,
	output logic                           ag_o,
	output logic                           css_o,
	output logic [2:0]                     gfx_mode_o,
	output logic                           irq_o
);
	import vz_pkg::*;

	logic       ram_we;
	logic       vram_we;
	logic       latch_we;
	logic       gfx_we;
	logic [7:0] ram_dat;
	logic [7:0] vram_dat;
	logic [7:0] kbd_dat;
	logic [7:0] joy_dat;
	logic       joy_hit;

	vz_bus_decode u_bus_decode (
		.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.io_sel_i(io_sel_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
		.ram_we_o(ram_we), .vram_we_o(vram_we),
		.latch_we_o(latch_we), .gfx_we_o(gfx_we),
		.ram_dat_i(ram_dat), .vram_dat_i(vram_dat),
		.kbd_dat_i(kbd_dat), .joy_dat_i(joy_dat), .joy_hit_i(joy_hit)
	);

	// Low 14 bits fold 7800-B7FF onto 16 KB without an offset
	vz_main_ram #(.ADDR_W(RAM_ADDR_W)) u_main_ram (
		.CLK50MHZ(CLK50MHZ), .addr_i(wb_adr_i[RAM_ADDR_W-1:0]),
		.dat_i(wb_dat_i), .we_i(ram_we), .dat_o(ram_dat)
	);

	vz_video_ram #(.ADDR_W(VRAM_ADDR_W)) u_video_ram (
		.CLK50MHZ(CLK50MHZ), .cpu_addr_i(wb_adr_i.mem.offset),
		.cpu_dat_i(wb_dat_i), .cpu_we_i(vram_we), .cpu_dat_o(vram_dat),
		.vid_addr_i(vid_addr_i), .vid_data_o(vid_data_o)
	);

	vz_keyboard u_keyboard (
		.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N),
		.key_strobe_i(key_strobe_i), .key_code_i(key_code_i),
		.key_pressed_i(key_pressed_i), .key_extended_i(key_extended_i),
		.row_sel_i(wb_adr_i.io.port), // Row strobes on A7..A0
		.cass_in_i(cass_in_i), .kbd_dat_o(kbd_dat)
	);

	vz_io_ports #(.GFX_MODE_EN(GFX_MODE_EN)) u_io_ports (
		.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N),
		.dat_i(wb_dat_i), .latch_we_i(latch_we), .gfx_we_i(gfx_we),
		.port_i(wb_adr_i.io.port),
		.joy1_i(joy1_i), .joy2_i(joy2_i), .arm1_i(arm1_i), .arm2_i(arm2_i),
		.joy_dat_o(joy_dat), .joy_hit_o(joy_hit),
		.spk_o(spk_o), .cass_out_o(cass_out_o), .ag_o(ag_o), .css_o(css_o),
		.gfx_mode_o(gfx_mode_o)
	);

	vz_frame_irq #(.FRAME_CYCLES(FRAME_CYCLES), .IRQ_CYCLES(IRQ_CYCLES)) u_frame_irq (
		.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N), .irq_o(irq_o)
	);

endmodule

/* rtl/vz_bus_decode.sv */
`timescale 1ns/1ns

module vz_bus_decode (
	input  logic             CLK50MHZ,
	input  logic             RESET_N,
	input  logic             wb_cyc_i,
	input  logic             wb_stb_i,
	input  logic             wb_we_i,
	input  logic             io_sel_i,   // High for port cycles
	input  vz_pkg::vz_addr_u wb_adr_i,
	input  logic [7:0]       wb_dat_i,
	output logic [7:0]       wb_dat_o,
	output logic             wb_ack_o,
	output logic             ram_we_o,
	output logic             vram_we_o,
	output logic             latch_we_o,
	output logic             gfx_we_o,
	input  logic [7:0]       ram_dat_i,  // Registered inside the RAM
	input  logic [7:0]       vram_dat_i,
	input  logic [7:0]       kbd_dat_i,  // Combinational from address
	input  logic [7:0]       joy_dat_i,
	input  logic             joy_hit_i
);
	import vz_pkg::*;

	// Read source seen in the acknowledge cycle
	localparam logic [1:0] SEL_HOLD = 2'd0; // Captured keyboard, joystick or FFh
	localparam logic [1:0] SEL_RAM  = 2'd1;
	localparam logic [1:0] SEL_VRAM = 2'd2;

	logic       req;       // First cycle of an access
	logic       hit_kbd;
	logic       hit_vram;
	logic       hit_ram;
	logic       hit_gfx;
	logic       wr;
	logic [7:0] hold_dat;
	logic [7:0] hold_q;
	logic [1:0] sel_q;
	logic       ack_q;

	// A held strobe only restarts after the acknowledge cycle
	assign req = wb_cyc_i & wb_stb_i & ~ack_q;
	assign wr  = req & wb_we_i;

	// Memory view
	assign hit_kbd  = ~io_sel_i & (wb_adr_i.mem.page == PAGE_IO);
	assign hit_vram = ~io_sel_i & (wb_adr_i.mem.page == PAGE_VRAM);
	assign hit_ram  = ~io_sel_i & (wb_adr_i.mem.page >= PAGE_RAM_FIRST)
		& (wb_adr_i.mem.page <= PAGE_RAM_LAST);
	// Port view
	assign hit_gfx  = io_sel_i & (wb_adr_i.io.port == PORT_GFX_MODE);

	// Strobes land on the edge that raises ack
	assign ram_we_o   = wr & hit_ram;
	assign vram_we_o  = wr & hit_vram;
	assign latch_we_o = wr & hit_kbd; // Writes to 6800 page hit the latch
	assign gfx_we_o   = wr & hit_gfx;

	always_comb
	begin
		if (hit_kbd)
			hold_dat = kbd_dat_i;
		else if (io_sel_i & joy_hit_i)
			hold_dat = joy_dat_i;
		else
			hold_dat = UNMAPPED_DATA; // Mode register is write only
	end

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			ack_q <= 1'b0;
			sel_q <= SEL_HOLD;
		end
		else
		begin
			ack_q <= req; // Exactly one wait state
			if (req)
				sel_q <= hit_ram ? SEL_RAM : hit_vram ? SEL_VRAM : SEL_HOLD;
		end
	end

	always_ff @(posedge CLK50MHZ)
		if (req)
			hold_q <= hold_dat;

	// RAM outputs are already one edge late, so they bypass hold_q
	always_comb
	begin
		case (sel_q)
			SEL_RAM:  wb_dat_o = ram_dat_i;
			SEL_VRAM: wb_dat_o = vram_dat_i;
			default:  wb_dat_o = hold_q;
		endcase
	end

	assign wb_ack_o = ack_q;

endmodule

/* rtl/vz_frame_irq.sv */
`timescale 1ns/1ns

module vz_frame_irq #(
	parameter int FRAME_CYCLES = 1000000, // 20 ms at 50 MHz
	parameter int IRQ_CYCLES   = 3200
) (
	input  logic CLK50MHZ,
	input  logic RESET_N,
	output logic irq_o
);

	localparam int CNT_W = $clog2(FRAME_CYCLES);

	logic [CNT_W-1:0] cnt_q;

	// Free running frame counter
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			cnt_q <= '0;
		else if (cnt_q == CNT_W'(FRAME_CYCLES - 1))
			cnt_q <= '0;
		else
			cnt_q <= cnt_q + 1'b1;
	end

	// Pulse at the start of each frame, so high straight out of reset
	assign irq_o = (cnt_q < CNT_W'(IRQ_CYCLES));

endmodule

/* rtl/vz_io_ports.sv */
`timescale 1ns/1ns

module vz_io_ports #(
	parameter bit GFX_MODE_EN = 1'b1 // Port 20h mode register present
) (
	input  logic       CLK50MHZ,
	input  logic       RESET_N,
	input  logic [7:0] dat_i,
	input  logic       latch_we_i,
	input  logic       gfx_we_i,
	input  logic [7:0] port_i,
	input  logic [4:0] joy1_i,  // Bit 0 up, 1 down, 2 left, 3 right, 4 fire
	input  logic [4:0] joy2_i,
	input  logic       arm1_i,
	input  logic       arm2_i,
	output logic [7:0] joy_dat_o,
	output logic       joy_hit_o,
	output logic [1:0] spk_o,
	output logic       cass_out_o,
	output logic       ag_o,
	output logic       css_o,
	output logic [2:0] gfx_mode_o
);
	import vz_pkg::*;

	// Output latch at 6800, only the wired bits kept
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			spk_o      <= 2'b00;
			cass_out_o <= 1'b0;
			ag_o       <= 1'b0;
			css_o      <= 1'b0;
			gfx_mode_o <= GFX_MODE_RESET[4:2];
		end
		else
		begin
			if (latch_we_i)
			begin
				spk_o      <= {dat_i[0], dat_i[5]}; // Push-pull speaker pair
				cass_out_o <= dat_i[2];
				ag_o       <= dat_i[3]; // Alpha or graphics
				css_o      <= dat_i[4]; // Colour set
			end
			if (gfx_we_i && GFX_MODE_EN)
				gfx_mode_o <= dat_i[4:2];
		end
	end

	// Joystick ports read active low
	always_comb
	begin
		joy_hit_o = 1'b1;
		case (port_i)
			PORT_JOY1_DIR: joy_dat_o = {3'b111, ~joy1_i};
			PORT_JOY1_ARM: joy_dat_o = {3'b111, ~arm1_i, 4'b1111};
			PORT_JOY2_DIR: joy_dat_o = {3'b111, ~joy2_i};
			PORT_JOY2_ARM: joy_dat_o = {3'b111, ~arm2_i, 4'b1111};
			default:
			begin
				joy_hit_o = 1'b0;
				joy_dat_o = UNMAPPED_DATA;
			end
		endcase
	end

endmodule

/* rtl/vz_keyboard.sv */
`timescale 1ns/1ns

module vz_keyboard (
	input  logic       CLK50MHZ,
	input  logic       RESET_N,
	input  logic       key_strobe_i,   // One cycle per scan code event
	input  logic [7:0] key_code_i,
	input  logic       key_pressed_i,
	input  logic       key_extended_i, // E0 prefix seen
	input  logic [7:0] row_sel_i,      // Low address byte, 0 selects a row
	input  logic       cass_in_i,
	output logic [7:0] kbd_dat_o
);

	// Extension bit positions
	localparam int EX_RSHIFT = 0;
	localparam int EX_ESC    = 1;
	localparam int EX_UP     = 2;
	localparam int EX_LEFT   = 3;
	localparam int EX_RIGHT  = 4;
	localparam int EX_DOWN   = 5;
	localparam int EX_BKSP   = 6;

	logic [63:0] key_q;   // Row r, column c at 8*r+c, 0 = down
	logic [6:0]  ex_q;    // Extension keys, 0 = down
	logic [63:0] key_eff; // Matrix with extensions folded in
	logic [5:0]  col;
	logic        press_n;

	assign press_n = ~key_pressed_i;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			key_q <= '1;
			ex_q  <= '1;
		end
		else if (key_strobe_i)
		begin
			case (key_code_i)
				8'h16: key_q[28] <= press_n; // 1
				8'h1E: key_q[25] <= press_n; // 2
				8'h26: key_q[27] <= press_n; // 3
				8'h25: key_q[29] <= press_n; // 4
				8'h2E: key_q[24] <= press_n; // 5
				8'h36: key_q[40] <= press_n; // 6
				8'h3D: key_q[45] <= press_n; // 7
				8'h3E: key_q[43] <= press_n; // 8
				8'h46: key_q[41] <= press_n; // 9
				8'h45: key_q[44] <= press_n; // 0
				8'h4E: key_q[42] <= press_n; // Minus
				8'h49: key_q[33] <= press_n; // Period
				8'h41: key_q[35] <= press_n; // Comma
				8'h4C: key_q[60] <= press_n; // Semicolon
				8'h52: key_q[58] <= press_n; // Quote maps to colon
				8'h5A: key_q[50] <= press_n; // Return
				8'h29: key_q[36] <= press_n; // Space
				8'h15: key_q[4]  <= press_n; // Q
				8'h1D: key_q[1]  <= press_n; // W
				8'h24: key_q[3]  <= press_n; // E
				8'h2D: key_q[5]  <= press_n; // R
				8'h2C: key_q[0]  <= press_n; // T
				8'h35: key_q[48] <= press_n; // Y
				8'h3C: key_q[53] <= press_n; // U
				8'h43: key_q[51] <= press_n; // I
				8'h44: key_q[49] <= press_n; // O
				8'h4D: key_q[52] <= press_n; // P
				8'h1C: key_q[12] <= press_n; // A
				8'h1B: key_q[9]  <= press_n; // S
				8'h23: key_q[11] <= press_n; // D
				8'h2B: key_q[13] <= press_n; // F
				8'h34: key_q[8]  <= press_n; // G
				8'h33: key_q[56] <= press_n; // H
				8'h3B: key_q[61] <= press_n; // J
				8'h42: key_q[59] <= press_n; // K
				8'h4B: key_q[57] <= press_n; // L
				8'h1A: key_q[20] <= press_n; // Z
				8'h22: key_q[17] <= press_n; // X
				8'h21: key_q[19] <= press_n; // C
				8'h2A: key_q[21] <= press_n; // V
				8'h32: key_q[16] <= press_n; // B
				8'h31: key_q[32] <= press_n; // N
				8'h3A: key_q[37] <= press_n; // M
				8'h14: key_q[10] <= press_n; // Either Ctrl
				8'h12: key_q[18] <= press_n; // Left Shift
				8'h59: ex_q[EX_RSHIFT] <= press_n;
				8'h76: ex_q[EX_ESC]    <= press_n;
				8'h66: ex_q[EX_BKSP]   <= press_n;
				// Arrows only with E0, the plain codes are keypad digits
				8'h75: if (key_extended_i) ex_q[EX_UP]    <= press_n;
				8'h6B: if (key_extended_i) ex_q[EX_LEFT]  <= press_n;
				8'h74: if (key_extended_i) ex_q[EX_RIGHT] <= press_n;
				8'h72: if (key_extended_i) ex_q[EX_DOWN]  <= press_n;
				default: ;
			endcase
		end
	end

	always_comb
	begin
		key_eff     = key_q;
		key_eff[37] = key_q[37] & ex_q[EX_LEFT] & ex_q[EX_BKSP]; // M
		key_eff[35] = key_q[35] & ex_q[EX_RIGHT];  // Comma
		key_eff[33] = key_q[33] & ex_q[EX_UP];     // Period
		key_eff[36] = key_q[36] & ex_q[EX_DOWN];   // Space
		key_eff[42] = key_q[42] & ex_q[EX_ESC];    // Minus
		key_eff[18] = key_q[18] & ex_q[EX_RSHIFT]; // Both shifts on one key
		key_eff[10] = key_q[10] & (&ex_q[EX_BKSP:EX_ESC]); // Ctrl for the rest

		// Column is low if any selected row holds a pressed key
		for (int c = 0; c < 6; c++)
		begin
			col[c] = 1'b1;
			for (int r = 0; r < 8; r++)
				col[c] = col[c] & (row_sel_i[r] | key_eff[8*r + c]);
		end
	end

	assign kbd_dat_o = {1'b1, ~cass_in_i, col}; // Bit 7 always reads high

endmodule

/* rtl/vz_video_ram.sv */
`timescale 1ns/1ns

module vz_video_ram #(
	parameter int ADDR_W = vz_pkg::VRAM_ADDR_W
) (
	input  logic              CLK50MHZ,
	input  logic [ADDR_W-1:0] cpu_addr_i,
	input  logic [7:0]        cpu_dat_i,
	input  logic              cpu_we_i,
	output logic [7:0]        cpu_dat_o,
	input  logic [ADDR_W-1:0] vid_addr_i, // Display engine side
	output logic [7:0]        vid_data_o
);

	logic [7:0] mem [0:(1 << ADDR_W)-1];

	// CPU port, read and write
	always_ff @(posedge CLK50MHZ)
	begin
		if (cpu_we_i)
			mem[cpu_addr_i] <= cpu_dat_i;
		cpu_dat_o <= mem[cpu_addr_i];
	end

	// Display port is read only
	always_ff @(posedge CLK50MHZ)
		vid_data_o <= mem[vid_addr_i];

endmodule

/* rtl/vz_main_ram.sv */
`timescale 1ns/1ns

module vz_main_ram #(
	parameter int ADDR_W = vz_pkg::RAM_ADDR_W
) (
	input  logic              CLK50MHZ,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [7:0]        dat_i,
	input  logic              we_i,
	output logic [7:0]        dat_o
);

	logic [7:0] mem [0:(1 << ADDR_W)-1];

	// Single port, read during write returns the old byte
	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i)
			mem[addr_i] <= dat_i;
		dat_o <= mem[addr_i];
	end

endmodule

/* rtl/vz_pkg.sv */
package vz_pkg;

	// One 16-bit bus address, read either as memory or as an I/O port
	typedef union packed {
		struct packed {
			logic [4:0]  page;   // 2 KB page, A15..A11
			logic [10:0] offset; // Byte within the page
		} mem;
		struct packed {
			logic [7:0] high;    // Upper byte, ignored by the port decode
			logic [7:0] port;    // Z80 style 8-bit port number
		} io;
	} vz_addr_u;

	// Memory map, in 2 KB pages
	localparam logic [4:0] PAGE_IO        = 5'h0D; // 6800-6FFF keyboard and latch
	localparam logic [4:0] PAGE_VRAM      = 5'h0E; // 7000-77FF
	localparam logic [4:0] PAGE_RAM_FIRST = 5'h0F; // 7800
	localparam logic [4:0] PAGE_RAM_LAST  = 5'h16; // Up to B7FF

	// I/O ports
	localparam logic [7:0] PORT_GFX_MODE = 8'h20; // Extended graphics mode
	localparam logic [7:0] PORT_JOY1_DIR = 8'h2E;
	localparam logic [7:0] PORT_JOY1_ARM = 8'h2D;
	localparam logic [7:0] PORT_JOY2_DIR = 8'h2B;
	localparam logic [7:0] PORT_JOY2_ARM = 8'h27;

	// Mode register after reset, GM = 010
	localparam logic [7:0] GFX_MODE_RESET = 8'h08;

	// Nothing drives the bus there
	localparam logic [7:0] UNMAPPED_DATA = 8'hFF;

	// RAM sizes
	localparam int RAM_ADDR_W  = 14; // 16 KB main RAM
	localparam int VRAM_ADDR_W = 11; // 2 KB video RAM

endpackage
